/* include/icp_lsm_defines.svh */
// ICP least-squares row widths and pipeline latency

`ifndef ICP_LSM_DEFINES_SVH
`define ICP_LSM_DEFINES_SVH

// ==================================================
// data widths
// ==================================================

// signed point / normal coordinate
`define ICP_CLOUD_BW 16

// signed pose entry, rotation part scaled by 2^ICP_POSE_FRAC
`define ICP_POSE_BW 16

// fractional bits of the rotation entries
`define ICP_POSE_FRAC 12

// correspondence counter
`define ICP_COUNT_BW 20

// ==================================================
// timing
// ==================================================

// input row to output row, 2 transform + 3 residual stages
`define ICP_ROW_LAT 5

`endif

/* rtl/icp_geom_pkg.sv */
// geometry types for points, poses, products and the error accumulator

`default_nettype none

`include "icp_lsm_defines.svh"

package icp_geom_pkg;

    // point or normal coordinate
    typedef logic signed [`ICP_CLOUD_BW-1:0] cloud_t;

    // R entries 0..8 row-major, then t 9..11 in cloud units
    typedef logic signed [`ICP_POSE_BW-1:0] pose_t;

    // products, residual, jacobian and weight, wrapping
    typedef logic signed [2*`ICP_CLOUD_BW-1:0] prod_t;

    // sum of squared residuals, wrapping
    typedef logic signed [4*`ICP_CLOUD_BW-1:0] acc_t;

endpackage

`default_nettype wire

/* rtl/icp_stream_pkg.sv */
// stream types for sideband flags and correspondence count

`default_nettype none

`include "icp_lsm_defines.svh"

package icp_stream_pkg;

    // {frame_start, frame_end, valid, corresps_valid}
    typedef logic [3:0] side_t;

    typedef logic [`ICP_COUNT_BW-1:0] count_t;

endpackage

`default_nettype wire

/* rtl/icp_point_transform.sv */
// two-stage rigid transform of p0, with p1, n1 and flags delayed alongside
`timescale 1ns/10ps

`default_nettype none

`include "icp_lsm_defines.svh"

module icp_point_transform
    import icp_geom_pkg::*, icp_stream_pkg::*;
(
     input  logic   i_clk
    ,input  logic   i_rst_n
    ,input  logic   i_frame_start
    ,input  logic   i_frame_end
    ,input  logic   i_valid
    ,input  logic   i_corresps_valid
    ,input  cloud_t i_p0_x
    ,input  cloud_t i_p0_y
    ,input  cloud_t i_p0_z
    ,input  cloud_t i_p1_x
    ,input  cloud_t i_p1_y
    ,input  cloud_t i_p1_z
    ,input  cloud_t i_n1_x
    ,input  cloud_t i_n1_y
    ,input  cloud_t i_n1_z
    ,input  pose_t  i_pose [12]
    ,output side_t  o_side
    ,output cloud_t o_tp0_x
    ,output cloud_t o_tp0_y
    ,output cloud_t o_tp0_z
    ,output cloud_t o_p1_x
    ,output cloud_t o_p1_y
    ,output cloud_t o_p1_z
    ,output cloud_t o_n1_x
    ,output cloud_t o_n1_y
    ,output cloud_t o_n1_z
);

    cloud_t p0 [3];
    prod_t  rot_prod [3][3];   // R[i][j] * p0[j]
    prod_t  t_scaled [3];      // t aligned to the rotation fraction
    cloud_t p1_s1 [3];
    cloud_t n1_s1 [3];
    side_t  side_s1;

    logic signed [2*`ICP_CLOUD_BW+1:0] row_sum [3];
    logic signed [2*`ICP_CLOUD_BW+1:0] row_shift [3];
    cloud_t tp0_s2 [3];

    assign p0 = '{i_p0_x, i_p0_y, i_p0_z};

    //==================================================
    // stage 1: products and scaled translation
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    rot_prod[i][j] <= '0;
                end
                t_scaled[i] <= '0;
            end
            p1_s1   <= '{default: '0};
            n1_s1   <= '{default: '0};
            side_s1 <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    rot_prod[i][j] <= i_pose[3*i+j] * p0[j];
                end
                t_scaled[i] <= prod_t'(i_pose[9+i]) <<< `ICP_POSE_FRAC;
            end
            p1_s1   <= '{i_p1_x, i_p1_y, i_p1_z};
            n1_s1   <= '{i_n1_x, i_n1_y, i_n1_z};
            side_s1 <= {i_frame_start, i_frame_end, i_valid, i_corresps_valid};
        end
    end

    //==================================================
    // stage 2: row sums, floor shift, wrap
    //==================================================
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            row_sum[i]   = rot_prod[i][0] + rot_prod[i][1] + rot_prod[i][2] + t_scaled[i];
            row_shift[i] = row_sum[i] >>> `ICP_POSE_FRAC;   // floor, not round
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tp0_s2 <= '{default: '0};
            o_p1_x <= '0;
            o_p1_y <= '0;
            o_p1_z <= '0;
            o_n1_x <= '0;
            o_n1_y <= '0;
            o_n1_z <= '0;
            o_side <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                tp0_s2[i] <= row_shift[i][`ICP_CLOUD_BW-1:0];
            end
            o_p1_x <= p1_s1[0];
            o_p1_y <= p1_s1[1];
            o_p1_z <= p1_s1[2];
            o_n1_x <= n1_s1[0];
            o_n1_y <= n1_s1[1];
            o_n1_z <= n1_s1[2];
            o_side <= side_s1;
        end
    end

    assign o_tp0_x = tp0_s2[0];
    assign o_tp0_y = tp0_s2[1];
    assign o_tp0_z = tp0_s2[2];

    // flags must stay known once out of reset
    a_side_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !$isunknown(o_side)
    );

endmodule

`default_nettype wire

/* rtl/icp_residual_jacobian.sv */
// three-stage point-to-plane residual, cross-product jacobian and robust weight
`timescale 1ns/10ps

`default_nettype none

module icp_residual_jacobian
    import icp_geom_pkg::*, icp_stream_pkg::*;
(
     input  logic   i_clk
    ,input  logic   i_rst_n
    ,input  side_t  i_side
    ,input  prod_t  i_sigma_icp
    ,input  cloud_t i_tp0_x
    ,input  cloud_t i_tp0_y
    ,input  cloud_t i_tp0_z
    ,input  cloud_t i_p1_x
    ,input  cloud_t i_p1_y
    ,input  cloud_t i_p1_z
    ,input  cloud_t i_n1_x
    ,input  cloud_t i_n1_y
    ,input  cloud_t i_n1_z
    ,output side_t  o_side
    ,output prod_t  o_diff
    ,output prod_t  o_a0
    ,output prod_t  o_a1
    ,output prod_t  o_a2
    ,output prod_t  o_w
    ,output cloud_t o_n1_x
    ,output cloud_t o_n1_y
    ,output cloud_t o_n1_z
);

    // stage 1
    cloud_t v_s1 [3];
    cloud_t tp0_s1 [3];
    cloud_t n1_s1 [3];
    side_t  side_s1;
    prod_t  sigma_s1;

    // stage 2
    prod_t  dot_s2 [3];      // v_i * n_i
    prod_t  cross_s2 [6];    // minuend/subtrahend pairs for A0..A2
    cloud_t n1_s2 [3];
    side_t  side_s2;
    prod_t  sigma_s2;

    // stage 3
    prod_t  diff_w;
    prod_t  diff_abs;
    prod_t  w_w;
    cloud_t n1_s3 [3];

    //==================================================
    // stage 1: v = p1 - tp0
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            v_s1     <= '{default: '0};
            tp0_s1   <= '{default: '0};
            n1_s1    <= '{default: '0};
            side_s1  <= '0;
            sigma_s1 <= '0;
        end else begin
            v_s1[0]  <= i_p1_x - i_tp0_x;   // wraps in cloud_t
            v_s1[1]  <= i_p1_y - i_tp0_y;
            v_s1[2]  <= i_p1_z - i_tp0_z;
            tp0_s1   <= '{i_tp0_x, i_tp0_y, i_tp0_z};
            n1_s1    <= '{i_n1_x, i_n1_y, i_n1_z};
            side_s1  <= i_side;
            sigma_s1 <= i_sigma_icp;
        end
    end

    //==================================================
    // stage 2: multipliers
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dot_s2   <= '{default: '0};
            cross_s2 <= '{default: '0};
            n1_s2    <= '{default: '0};
            side_s2  <= '0;
            sigma_s2 <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                dot_s2[i] <= v_s1[i] * n1_s1[i];
            end
            cross_s2[0] <= tp0_s1[1] * n1_s1[2];  // ty*nz
            cross_s2[1] <= tp0_s1[2] * n1_s1[1];  // tz*ny
            cross_s2[2] <= tp0_s1[2] * n1_s1[0];  // tz*nx
            cross_s2[3] <= tp0_s1[0] * n1_s1[2];  // tx*nz
            cross_s2[4] <= tp0_s1[0] * n1_s1[1];  // tx*ny
            cross_s2[5] <= tp0_s1[1] * n1_s1[0];  // ty*nx
            n1_s2    <= n1_s1;
            side_s2  <= side_s1;
            sigma_s2 <= sigma_s1;
        end
    end

    //==================================================
    // stage 3: sums, |diff| and weight
    //==================================================
    assign diff_w   = dot_s2[0] + dot_s2[1] + dot_s2[2];
    assign diff_abs = diff_w[$bits(prod_t)-1] ? -diff_w : diff_w;
    assign w_w      = sigma_s2 + diff_abs;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_diff <= '0;
            o_a0   <= '0;
            o_a1   <= '0;
            o_a2   <= '0;
            o_w    <= prod_t'(1);
            n1_s3  <= '{default: '0};
            o_side <= '0;
        end else begin
            o_diff <= diff_w;
            o_a0   <= cross_s2[0] - cross_s2[1];
            o_a1   <= cross_s2[2] - cross_s2[3];
            o_a2   <= cross_s2[4] - cross_s2[5];
            o_w    <= (w_w == '0) ? prod_t'(1) : w_w;   // downstream divides by w
            n1_s3  <= n1_s2;
            o_side <= side_s2;
        end
    end

    // n1 is the translational part A3..A5
    assign o_n1_x = n1_s3[0];
    assign o_n1_y = n1_s3[1];
    assign o_n1_z = n1_s3[2];

    a_w_nonzero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_w != '0
    );

endmodule

`default_nettype wire

/* rtl/icp_error_accum.sv */
// squared-residual accumulator and correspondence counter, cleared on update
`timescale 1ns/10ps

`default_nettype none

module icp_error_accum
    import icp_geom_pkg::*, icp_stream_pkg::*;
(
     input  logic   i_clk
    ,input  logic   i_rst_n
    ,input  logic   i_update_done
    ,input  logic   i_work_in     // working row at the block inputs
    ,input  logic   i_work_out    // working row at the block outputs
    ,input  prod_t  i_diff
    ,output acc_t   o_sigma_s_icp
    ,output count_t o_corresp_count
);

    acc_t diff_sq;

    // full signed square, fits in acc_t
    assign diff_sq = i_diff * i_diff;

    //==================================================
    // accumulators
    //==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sigma_s_icp <= '0;
        end else if (i_update_done) begin
            o_sigma_s_icp <= '0;
        end else if (i_work_out) begin
            o_sigma_s_icp <= o_sigma_s_icp + diff_sq;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_corresp_count <= '0;
        end else if (i_update_done) begin
            o_corresp_count <= '0;
        end else if (i_work_in) begin
            o_corresp_count <= o_corresp_count + 1'b1;
        end
    end

    // no input row and no clear means the count holds
    a_count_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (!i_work_in && !i_update_done) |=> $stable(o_corresp_count)
    );

endmodule

`default_nettype wire

/* rtl/icp_lsm_row.sv */
// top level of the point-to-plane ICP row, transform -> residual -> accumulate
`timescale 1ns/10ps

`default_nettype none

module icp_lsm_row
    import icp_geom_pkg::*, icp_stream_pkg::*;
(
     input  logic   i_clk
    ,input  logic   i_rst_n
    ,input  logic   i_frame_start
    ,input  logic   i_frame_end
    ,input  logic   i_valid
    ,input  logic   i_corresps_valid
    ,input  cloud_t i_p0_x
    ,input  cloud_t i_p0_y
    ,input  cloud_t i_p0_z
    ,input  cloud_t i_p1_x
    ,input  cloud_t i_p1_y
    ,input  cloud_t i_p1_z
    ,input  cloud_t i_n1_x
    ,input  cloud_t i_n1_y
    ,input  cloud_t i_n1_z
    ,input  pose_t  i_pose [12]
    ,input  prod_t  i_sigma_icp   // stable within a frame
    ,input  logic   i_update_done
    ,output logic   o_frame_start
    ,output logic   o_frame_end
    ,output logic   o_valid
    ,output logic   o_corresps_valid
    ,output prod_t  o_a0
    ,output prod_t  o_a1
    ,output prod_t  o_a2
    ,output prod_t  o_a3
    ,output prod_t  o_a4
    ,output prod_t  o_a5
    ,output prod_t  o_diff
    ,output prod_t  o_w
    ,output acc_t   o_sigma_s_icp
    ,output count_t o_corresp_count
);

    // transform -> residual
    side_t  tr_side;
    cloud_t tp0_x, tp0_y, tp0_z;
    cloud_t p1_x, p1_y, p1_z;
    cloud_t n1_x, n1_y, n1_z;

    // residual -> outputs
    side_t  res_side;
    cloud_t res_n1_x, res_n1_y, res_n1_z;

    logic work_in;
    logic work_out;

    //==================================================
    // decode: rigid transform
    //==================================================
    icp_point_transform u_transform (
         .i_clk            ( i_clk )
        ,.i_rst_n          ( i_rst_n )
        ,.i_frame_start    ( i_frame_start )
        ,.i_frame_end      ( i_frame_end )
        ,.i_valid          ( i_valid )
        ,.i_corresps_valid ( i_corresps_valid )
        ,.i_p0_x           ( i_p0_x )
        ,.i_p0_y           ( i_p0_y )
        ,.i_p0_z           ( i_p0_z )
        ,.i_p1_x           ( i_p1_x )
        ,.i_p1_y           ( i_p1_y )
        ,.i_p1_z           ( i_p1_z )
        ,.i_n1_x           ( i_n1_x )
        ,.i_n1_y           ( i_n1_y )
        ,.i_n1_z           ( i_n1_z )
        ,.i_pose           ( i_pose )
        ,.o_side           ( tr_side )
        ,.o_tp0_x          ( tp0_x )
        ,.o_tp0_y          ( tp0_y )
        ,.o_tp0_z          ( tp0_z )
        ,.o_p1_x           ( p1_x )
        ,.o_p1_y           ( p1_y )
        ,.o_p1_z           ( p1_z )
        ,.o_n1_x           ( n1_x )
        ,.o_n1_y           ( n1_y )
        ,.o_n1_z           ( n1_z )
    );

    //==================================================
    // execute: residual, jacobian, weight
    //==================================================
    icp_residual_jacobian u_residual (
         .i_clk       ( i_clk )
        ,.i_rst_n     ( i_rst_n )
        ,.i_side      ( tr_side )
        ,.i_sigma_icp ( i_sigma_icp )
        ,.i_tp0_x     ( tp0_x )
        ,.i_tp0_y     ( tp0_y )
        ,.i_tp0_z     ( tp0_z )
        ,.i_p1_x      ( p1_x )
        ,.i_p1_y      ( p1_y )
        ,.i_p1_z      ( p1_z )
        ,.i_n1_x      ( n1_x )
        ,.i_n1_y      ( n1_y )
        ,.i_n1_z      ( n1_z )
        ,.o_side      ( res_side )
        ,.o_diff      ( o_diff )
        ,.o_a0        ( o_a0 )
        ,.o_a1        ( o_a1 )
        ,.o_a2        ( o_a2 )
        ,.o_w         ( o_w )
        ,.o_n1_x      ( res_n1_x )
        ,.o_n1_y      ( res_n1_y )
        ,.o_n1_z      ( res_n1_z )
    );

    //==================================================
    // result: error and count
    //==================================================
    assign work_in  = i_valid & i_corresps_valid;
    assign work_out = res_side[1] & res_side[0];

    icp_error_accum u_accum (
         .i_clk           ( i_clk )
        ,.i_rst_n         ( i_rst_n )
        ,.i_update_done   ( i_update_done )
        ,.i_work_in       ( work_in )
        ,.i_work_out      ( work_out )
        ,.i_diff          ( o_diff )
        ,.o_sigma_s_icp   ( o_sigma_s_icp )
        ,.o_corresp_count ( o_corresp_count )
    );

    assign {o_frame_start, o_frame_end, o_valid, o_corresps_valid} = res_side;

    // sign-extended normal as A3..A5
    assign o_a3 = prod_t'(res_n1_x);
    assign o_a4 = prod_t'(res_n1_y);
    assign o_a5 = prod_t'(res_n1_z);

endmodule

`default_nettype wire

/* tb/icp_lsm_checker.sv */
// ICP row reference model, per-row output checks and accumulator tracking
`timescale 1ns/10ps

`default_nettype none

`include "icp_lsm_defines.svh"

module icp_lsm_checker
    import icp_geom_pkg::*, icp_stream_pkg::*;
(
     input  logic                         i_clk
    ,input  logic                         i_rst_n
    ,input  side_t                        i_side_in      // flags at the DUT inputs
    ,input  logic [3*`ICP_CLOUD_BW-1:0]   i_p0           // {x, y, z}
    ,input  logic [3*`ICP_CLOUD_BW-1:0]   i_p1
    ,input  logic [3*`ICP_CLOUD_BW-1:0]   i_n1
    ,input  pose_t                        i_pose [12]
    ,input  prod_t                        i_sigma_icp
    ,input  logic                         i_update_done
    ,input  side_t                        i_side_out     // flags at the DUT outputs
    ,input  logic [12*`ICP_CLOUD_BW-1:0]  i_jac          // {a0 .. a5}
    ,input  prod_t                        i_diff
    ,input  prod_t                        i_w
    ,input  acc_t                         i_sigma_s_icp
    ,input  count_t                       i_corresp_count
    ,output int                           o_checks
    ,output int                           o_row_errs
    ,output int                           o_acc_errs
    ,output int                           o_rst_errs
);

    localparam int JAC_W = 12 * `ICP_CLOUD_BW;

    side_t            side_q [$];
    prod_t            diff_q [$];
    prod_t            w_q [$];
    logic [JAC_W-1:0] jac_q [$];

    prod_t            new_diff;
    prod_t            new_w;
    logic [JAC_W-1:0] new_jac;
    side_t            old_side;
    prod_t            old_diff;
    prod_t            old_w;
    logic [JAC_W-1:0] old_jac;
    logic             popped;
    acc_t             sum_model;
    count_t           cnt_model;

    function automatic cloud_t to_cloud(input longint x);
        return x[`ICP_CLOUD_BW-1:0];
    endfunction

    function automatic prod_t to_prod(input longint x);
        return x[2*`ICP_CLOUD_BW-1:0];
    endfunction

    task automatic compare(input string what, input logic [JAC_W-1:0] exp,
                           input logic [JAC_W-1:0] got, inout int errs);
        o_checks++;
        if (got !== exp) begin
            errs++;
            $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, what, exp, got);
        end
    endtask

    //==================================================
    // reference row from the sampled inputs
    //==================================================
    task automatic build_row(output prod_t diff, output logic [JAC_W-1:0] jac,
                             output prod_t w);
        longint p0 [3];
        longint p1 [3];
        longint n1 [3];
        cloud_t tp [3];
        prod_t  a [3];
        longint sum;
        longint mag;
        for (int i = 0; i < 3; i++) begin
            p0[i] = $signed(i_p0[`ICP_CLOUD_BW*(2-i) +: `ICP_CLOUD_BW]);
            p1[i] = $signed(i_p1[`ICP_CLOUD_BW*(2-i) +: `ICP_CLOUD_BW]);
            n1[i] = $signed(i_n1[`ICP_CLOUD_BW*(2-i) +: `ICP_CLOUD_BW]);
        end
        for (int i = 0; i < 3; i++) begin
            sum = longint'(i_pose[9+i]) * (longint'(1) << `ICP_POSE_FRAC);
            for (int j = 0; j < 3; j++) begin
                sum += longint'(i_pose[3*i+j]) * p0[j];
            end
            tp[i] = to_cloud(sum >>> `ICP_POSE_FRAC);   // floor of R*p0 / 2^frac, plus t
        end
        sum = 0;
        for (int i = 0; i < 3; i++) begin
            sum += longint'(to_cloud(p1[i] - tp[i])) * n1[i];
        end
        diff = to_prod(sum);
        a[0] = to_prod(tp[1] * n1[2] - tp[2] * n1[1]);
        a[1] = to_prod(tp[2] * n1[0] - tp[0] * n1[2]);
        a[2] = to_prod(tp[0] * n1[1] - tp[1] * n1[0]);
        mag  = (diff < 0) ? -longint'(diff) : longint'(diff);
        w    = to_prod(longint'(i_sigma_icp) + mag);
        if (w == 0) begin
            w = 1;
        end
        jac = {a[0], a[1], a[2], to_prod(n1[0]), to_prod(n1[1]), to_prod(n1[2])};
    endtask

    initial begin
        o_checks   = 0;
        o_row_errs = 0;
        o_acc_errs = 0;
        o_rst_errs = 0;
    end

    //==================================================
    // compare on the falling edge, away from the drive edge
    //==================================================
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            compare("flags in reset", '0, i_side_out, o_rst_errs);
            compare("weight in reset", 1, i_w, o_rst_errs);
            compare("sigma_s_icp in reset", '0, i_sigma_s_icp, o_rst_errs);
            compare("corresp_count in reset", '0, i_corresp_count, o_rst_errs);
            side_q.delete();
            diff_q.delete();
            w_q.delete();
            jac_q.delete();
            sum_model = '0;
            cnt_model = '0;
        end else begin
            compare("sigma_s_icp", sum_model, i_sigma_s_icp, o_acc_errs);
            compare("corresp_count", cnt_model, i_corresp_count, o_acc_errs);
            build_row(new_diff, new_jac, new_w);
            side_q.push_back(i_side_in);
            diff_q.push_back(new_diff);
            w_q.push_back(new_w);
            jac_q.push_back(new_jac);
            popped = 1'b0;
            if (side_q.size() > `ICP_ROW_LAT) begin
                popped   = 1'b1;
                old_side = side_q.pop_front();
                old_diff = diff_q.pop_front();
                old_w    = w_q.pop_front();
                old_jac  = jac_q.pop_front();
                compare("flags", old_side, i_side_out, o_row_errs);
                if (old_side[1]) begin   // data only matters on valid rows
                    compare("diff", old_diff, i_diff, o_row_errs);
                    compare("a0..a5", old_jac, i_jac, o_row_errs);
                    compare("w", old_w, i_w, o_row_errs);
                end
            end
            // state after the coming edge
            if (i_update_done) begin
                sum_model = '0;
                cnt_model = '0;
            end else begin
                if (popped && old_side[1] && old_side[0]) begin
                    sum_model = sum_model + acc_t'(longint'(old_diff) * longint'(old_diff));
                end
                if (i_side_in[1] && i_side_in[0]) begin
                    cnt_model = cnt_model + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_icp_lsm_row.sv */
// testbench for the ICP least-squares row, LFSR stimulus in framed bursts
`timescale 1ns/10ps

`default_nettype none

`include "icp_lsm_defines.svh"

module tb_icp_lsm_row
    import icp_geom_pkg::*, icp_stream_pkg::*;
();

    localparam int N_ROWS      = 2000;   // every driven cycle after reset
    localparam int GAP         = 3;      // idle rows between frames, sigma may change
    localparam int CLK_NS      = 40;
    localparam int WATCHDOG_NS = (N_ROWS + 16 + 50) * CLK_NS;

    logic   i_clk;
    logic   i_rst_n;
    logic   i_frame_start;
    logic   i_frame_end;
    logic   i_valid;
    logic   i_corresps_valid;
    cloud_t i_p0_x, i_p0_y, i_p0_z;
    cloud_t i_p1_x, i_p1_y, i_p1_z;
    cloud_t i_n1_x, i_n1_y, i_n1_z;
    pose_t  i_pose [12];
    prod_t  i_sigma_icp;
    logic   i_update_done;
    logic   o_frame_start, o_frame_end, o_valid, o_corresps_valid;
    prod_t  o_a0, o_a1, o_a2, o_a3, o_a4, o_a5;
    prod_t  o_diff;
    prod_t  o_w;
    acc_t   o_sigma_s_icp;
    count_t o_corresp_count;

    int          checks;
    int          row_errs;
    int          acc_errs;
    int          rst_errs;
    logic [31:0] lfsr;
    logic [47:0] r;
    int          sent;
    int          frame;
    int          len;
    logic        zero_frame;   // sigma 0 and some n1 = 0, so w must read 1

    icp_lsm_row i_dut (.*);

    icp_lsm_checker u_checker (
         .i_clk           ( i_clk )
        ,.i_rst_n         ( i_rst_n )
        ,.i_side_in       ( {i_frame_start, i_frame_end, i_valid, i_corresps_valid} )
        ,.i_p0            ( {i_p0_x, i_p0_y, i_p0_z} )
        ,.i_p1            ( {i_p1_x, i_p1_y, i_p1_z} )
        ,.i_n1            ( {i_n1_x, i_n1_y, i_n1_z} )
        ,.i_pose          ( i_pose )
        ,.i_sigma_icp     ( i_sigma_icp )
        ,.i_update_done   ( i_update_done )
        ,.i_side_out      ( {o_frame_start, o_frame_end, o_valid, o_corresps_valid} )
        ,.i_jac           ( {o_a0, o_a1, o_a2, o_a3, o_a4, o_a5} )
        ,.i_diff          ( o_diff )
        ,.i_w             ( o_w )
        ,.i_sigma_s_icp   ( o_sigma_s_icp )
        ,.i_corresp_count ( o_corresp_count )
        ,.o_checks        ( checks )
        ,.o_row_errs      ( row_errs )
        ,.o_acc_errs      ( acc_errs )
        ,.o_rst_errs      ( rst_errs )
    );

    always #(CLK_NS / 2) i_clk = ~i_clk;

    //==================================================
    // random source
    //==================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [47:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[46:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic send_row(input logic fs, input logic fe, input logic gap);
        logic [47:0] b;
        logic        zero_n;
        @(posedge i_clk);
        sent++;
        if (fs) begin   // new pose and sigma at frame start
            for (int k = 0; k < 9; k++) begin
                take_bits(13, b);
                i_pose[k] <= {{3{b[12]}}, b[12:0]};
            end
            for (int k = 9; k < 12; k++) begin
                take_bits(16, b);
                i_pose[k] <= b[15:0];
            end
            take_bits(16, b);
            i_sigma_icp <= zero_frame ? '0 : {16'h0, b[15:0]};
        end
        take_bits(3, b);
        i_valid <= !gap && (fe || b[2:0] != 3'd0);
        take_bits(2, b);
        i_corresps_valid <= fe || b[1:0] != 2'd0;
        i_frame_start <= fs;
        i_frame_end   <= fe;
        take_bits(6, b);
        i_update_done <= fe || (!gap && b[5:0] == 6'd0);   // frame end row always works
        take_bits(48, b);
        {i_p0_x, i_p0_y, i_p0_z} <= b;
        take_bits(48, b);
        {i_p1_x, i_p1_y, i_p1_z} <= b;
        take_bits(1, b);
        zero_n = zero_frame && b[0];
        take_bits(48, b);
        {i_n1_x, i_n1_y, i_n1_z} <= zero_n ? '0 : b;
    endtask

    //==================================================
    // stimulus
    //==================================================
    initial begin
        i_clk            = 1'b0;
        i_rst_n          = 1'b0;
        i_frame_start    = 1'b0;
        i_frame_end      = 1'b0;
        i_valid          = 1'b0;
        i_corresps_valid = 1'b0;
        {i_p0_x, i_p0_y, i_p0_z} = '0;
        {i_p1_x, i_p1_y, i_p1_z} = '0;
        {i_n1_x, i_n1_y, i_n1_z} = '0;
        for (int k = 0; k < 12; k++) begin
            i_pose[k] = '0;
        end
        i_sigma_icp   = '0;
        i_update_done = 1'b0;
        lfsr          = 32'd59;
        sent          = 0;
        frame         = 0;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        while (sent + GAP + 2 <= N_ROWS) begin
            take_bits(7, r);
            len = 150 + int'(r[6:0]);
            if (len > N_ROWS - sent - GAP) begin
                len = N_ROWS - sent - GAP;
            end
            zero_frame = (frame == 1);
            for (int k = 0; k < len; k++) begin
                send_row(k == 0, k == len - 1, 1'b0);
            end
            repeat (GAP) send_row(1'b0, 1'b0, 1'b1);
            frame++;
        end
        repeat (`ICP_ROW_LAT + 3) @(posedge i_clk);
        $display("checks %0d, errors: rows %0d, accumulators %0d, reset %0d",
                 checks, row_errs, acc_errs, rst_errs);
        if (checks > 0 && row_errs + acc_errs + rst_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // reset, all rows and the pipeline drain with margin
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* icp_lsm_row.f */
+incdir+include
rtl/icp_geom_pkg.sv
rtl/icp_stream_pkg.sv
rtl/icp_point_transform.sv
rtl/icp_residual_jacobian.sv
rtl/icp_error_accum.sv
rtl/icp_lsm_row.sv
tb/icp_lsm_checker.sv
tb/tb_icp_lsm_row.sv

/* Bender.yml */
package:
  name: icp_lsm_row

export_include_dirs:
  - include

sources:
  # packages first, the RTL modules import them
  - rtl/icp_geom_pkg.sv
  - rtl/icp_stream_pkg.sv
  - rtl/icp_point_transform.sv
  - rtl/icp_residual_jacobian.sv
  - rtl/icp_error_accum.sv
  - rtl/icp_lsm_row.sv

  - target: test
    files:
      - tb/icp_lsm_checker.sv
      - tb/tb_icp_lsm_row.sv
